// ==== design/pov_driver_pkg.sv ====
`default_nettype none

package pov_driver_pkg;

   // Column geometry
   localparam int N_DRIVERS = 30;
   localparam int CONF_BITS = 48;
   localparam int WRTGS_PER_ROW = 10;
   localparam int MUX_ROWS = 8;

   // Timing in enabled cycles
   localparam int BLANKING_TIME = 72;
   localparam int GCLK_IDLE_CYCLES = 512;
   localparam int WRTFC_WAIT = 6;
   localparam int DUMP_PAUSE = 5;
   localparam int CNT_W = $clog2(GCLK_IDLE_CYCLES + 2);

   // Latch command lengths
   localparam int LAT_FCWRTEN = 15;
   localparam int LAT_WRTFC = 5;
   localparam int LAT_READFC = 11;
   localparam int LAT_LATGS = 3;

   // Color c of LED p at bit 3p+c
   typedef logic [CONF_BITS-1:0] drv_word_t;
   typedef drv_word_t [N_DRIVERS-1:0] pixel_col_t;

   // Loaded into the drivers after reset
   localparam drv_word_t CONF_DEFAULT = '0;

   typedef enum logic [3:0] {STALL, PREPARE_CONFIG, CONFIG, WRTFC_TIMING, PREPARE_DUMP_CONFIG,
      DUMP_CONFIG, WAIT_FOR_NEXT_SLICE, BLANKING, PAUSE_SCLK, SHIFT_REGISTER} drv_state_e;

   typedef enum logic [1:0] {SIN_ZERO, SIN_CONF, SIN_PIXEL} sin_sel_e;

   typedef struct packed {
      logic sclk_en;
      logic gclk_en;
      logic lat_req;
      sin_sel_e sin_sel;
      logic [3:0] led_idx;
      logic [1:0] rgb_idx;
   } seq_ctrl_t;

   // Board wiring, shift slot to LED position, first entry is slot 15
   localparam logic [15:0][3:0] LUT0_RG = '{4'd6, 4'd7, 4'd9, 4'd8, 4'd10, 4'd11, 4'd13, 4'd12,
      4'd14, 4'd15, 4'd1, 4'd0, 4'd2, 4'd3, 4'd5, 4'd4};
   localparam logic [15:0][3:0] LUT0_B = '{4'd8, 4'd9, 4'd14, 4'd15, 4'd12, 4'd13, 4'd2, 4'd3,
      4'd0, 4'd1, 4'd6, 4'd7, 4'd4, 4'd5, 4'd10, 4'd11};
   localparam logic [15:0][3:0] LUT1_RG = '{4'd2, 4'd3, 4'd5, 4'd4, 4'd6, 4'd7, 4'd9, 4'd8,
      4'd10, 4'd11, 4'd13, 4'd12, 4'd14, 4'd15, 4'd1, 4'd0};
   localparam logic [15:0][3:0] LUT1_B = '{4'd0, 4'd1, 4'd6, 4'd7, 4'd4, 4'd5, 4'd9, 4'd11,
      4'd8, 4'd10, 4'd14, 4'd15, 4'd12, 4'd13, 4'd2, 4'd3};

endpackage

`default_nettype wire

// ==== design/conf_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module conf_serializer import pov_driver_pkg::*; (
   input logic clk,
   input logic nrst,
   input logic clk_enable,
   input drv_word_t serialized_conf,
   input logic new_configuration_ready,
   input logic conf_load,
   input logic conf_shift,
   output logic conf_pending,
   output logic conf_bit
);

   drv_word_t conf_store;
   drv_word_t conf_sreg;
   logic loaded;

   // Stored word, pending until the sequencer takes it
   // A new word wins over a load in the same cycle
   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         conf_store <= CONF_DEFAULT;
         conf_pending <= 1'b1;
         loaded <= 1'b0;
      end else begin
         if (new_configuration_ready) begin
            conf_store <= serialized_conf;
            conf_pending <= 1'b1;
         end else if (clk_enable && conf_load) begin
            conf_pending <= 1'b0;
         end
         if (clk_enable && conf_load) begin
            loaded <= 1'b1;
         end
      end
   end

   // Wire copy, untouched by a word arriving mid-transfer
   always_ff @(posedge clk) begin
      if (clk_enable) begin
         if (conf_load) begin
            conf_sreg <= conf_store;
         end else if (conf_shift) begin
            conf_sreg <= {conf_sreg[CONF_BITS-2:0], 1'b0};
         end
      end
   end

   // MSB first
   assign conf_bit = conf_sreg[CONF_BITS-1];

   // Shifting garbage means the sequencer skipped its load
   a_shift_after_load: assert property (@(posedge clk) disable iff (!nrst)
      (clk_enable && conf_shift) |-> loaded);

endmodule

`default_nettype wire

// ==== design/driver_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module driver_sequencer import pov_driver_pkg::*; (
   input logic clk,
   input logic nrst,
   input logic clk_enable,
   input logic position_sync,
   input logic conf_pending,
   output seq_ctrl_t ctrl,
   output logic conf_load,
   output logic conf_shift,
   output logic column_ready,
   output logic driver_ready
);

   drv_state_e state;
   logic [CNT_W-1:0] state_cnt;
   logic [$clog2(WRTGS_PER_ROW)-1:0] wrtgs_cnt;
   logic [$clog2(MUX_ROWS)-1:0] row_cnt;
   logic [3:0] led_idx;
   logic [1:0] rgb_idx;
   logic restart_ok;
   logic last_bit;

   // States a new configuration may interrupt
   assign restart_ok = state inside {BLANKING, WAIT_FOR_NEXT_SLICE, PAUSE_SCLK, SHIFT_REGISTER};
   assign last_bit = state_cnt == CONF_BITS - 1;

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         state <= STALL;
         state_cnt <= '0;
         wrtgs_cnt <= '0;
         row_cnt <= '0;
         led_idx <= '0;
         rgb_idx <= '0;
      end else if (clk_enable) begin
         state_cnt <= state_cnt + 1'b1;
         case (state)
            STALL: begin
               state <= PREPARE_CONFIG;
               state_cnt <= '0;
            end
            // FCWRTEN prelude
            PREPARE_CONFIG: if (state_cnt == LAT_FCWRTEN - 1) begin
               state <= CONFIG;
               state_cnt <= '0;
            end
            // One paused cycle, then the configuration bits
            CONFIG: if (state_cnt == CONF_BITS) begin
               state <= WRTFC_TIMING;
               state_cnt <= '0;
            end
            WRTFC_TIMING: if (state_cnt == WRTFC_WAIT - 1) begin
               state <= PREPARE_DUMP_CONFIG;
               state_cnt <= '0;
            end
            // READFC prelude
            PREPARE_DUMP_CONFIG: if (state_cnt == LAT_READFC - 1) begin
               state <= DUMP_CONFIG;
               state_cnt <= '0;
            end
            DUMP_CONFIG: if (state_cnt == CONF_BITS + DUMP_PAUSE - 1) begin
               state <= WAIT_FOR_NEXT_SLICE;
               state_cnt <= '0;
            end
            WAIT_FOR_NEXT_SLICE: begin
               // Saturate just past the idle count so column_ready fires once
               if (state_cnt > GCLK_IDLE_CYCLES) begin
                  state_cnt <= state_cnt;
               end
               if (position_sync) begin
                  state <= BLANKING;
                  state_cnt <= '0;
               end
            end
            BLANKING: if (state_cnt == BLANKING_TIME - 1) begin
               state <= PAUSE_SCLK;
               state_cnt <= '0;
            end
            PAUSE_SCLK: begin
               state <= SHIFT_REGISTER;
               state_cnt <= '0;
            end
            SHIFT_REGISTER: begin
               // 48 slots wrap led and rgb back to zero each group
               rgb_idx <= rgb_idx + 1'b1;
               if (rgb_idx == 2'd2) begin
                  rgb_idx <= '0;
                  led_idx <= led_idx + 1'b1;
               end
               if (last_bit) begin
                  state_cnt <= '0;
                  wrtgs_cnt <= wrtgs_cnt + 1'b1;
                  state <= PAUSE_SCLK;
                  if (wrtgs_cnt == WRTGS_PER_ROW - 1) begin
                     wrtgs_cnt <= '0;
                     row_cnt <= row_cnt + 1'b1;
                     state <= BLANKING;
                     if (row_cnt == MUX_ROWS - 1) begin
                        row_cnt <= '0;
                        state <= WAIT_FOR_NEXT_SLICE;
                     end
                  end
               end
            end
            default: begin
               state <= STALL;
               state_cnt <= '0;
            end
         endcase
         // New configuration restarts the boot sequence without STALL
         if (conf_pending && restart_ok) begin
            state <= PREPARE_CONFIG;
            state_cnt <= '0;
            wrtgs_cnt <= '0;
            row_cnt <= '0;
            led_idx <= '0;
            rgb_idx <= '0;
         end
      end
   end

   // Enables and latch windows per state
   always_comb begin
      ctrl = '0;
      ctrl.sin_sel = SIN_ZERO;
      case (state)
         PREPARE_CONFIG, PREPARE_DUMP_CONFIG: begin
            ctrl.sclk_en = 1'b1;
            ctrl.lat_req = 1'b1;
         end
         CONFIG: begin
            ctrl.sclk_en = state_cnt != '0;
            ctrl.lat_req = state_cnt >= CONF_BITS + 1 - LAT_WRTFC;
            ctrl.sin_sel = (state_cnt != '0) ? SIN_CONF : SIN_ZERO;
         end
         DUMP_CONFIG: ctrl.sclk_en = state_cnt >= DUMP_PAUSE;
         WAIT_FOR_NEXT_SLICE: ctrl.gclk_en = state_cnt < GCLK_IDLE_CYCLES;
         BLANKING: ctrl.gclk_en = state_cnt != '0;
         PAUSE_SCLK: ctrl.gclk_en = 1'b1;
         SHIFT_REGISTER: begin
            ctrl.sclk_en = 1'b1;
            ctrl.gclk_en = 1'b1;
            ctrl.sin_sel = SIN_PIXEL;
            // WRTGS on the last bit, LATGS over the last three of the row
            ctrl.lat_req = last_bit || (state_cnt >= CONF_BITS - LAT_LATGS
               && wrtgs_cnt == WRTGS_PER_ROW - 1);
         end
         default: ctrl.sin_sel = SIN_ZERO;
      endcase
      ctrl.led_idx = led_idx;
      ctrl.rgb_idx = rgb_idx;
   end

   // Serializer is reloaded as PREPARE_CONFIG ends
   assign conf_load = state == PREPARE_CONFIG && state_cnt == LAT_FCWRTEN - 1;
   assign conf_shift = state == CONFIG && state_cnt != '0 && state_cnt < CONF_BITS;

   assign column_ready = (state == SHIFT_REGISTER && last_bit && wrtgs_cnt == WRTGS_PER_ROW - 1
      && row_cnt == MUX_ROWS - 1) || (state == WAIT_FOR_NEXT_SLICE
      && state_cnt == GCLK_IDLE_CYCLES);
   assign driver_ready = state == SHIFT_REGISTER && clk_enable;

   a_state_legal: assert property (@(posedge clk) disable iff (!nrst)
      state inside {STALL, PREPARE_CONFIG, CONFIG, WRTFC_TIMING, PREPARE_DUMP_CONFIG, DUMP_CONFIG,
      WAIT_FOR_NEXT_SLICE, BLANKING, PAUSE_SCLK, SHIFT_REGISTER});

   // No latch command while idling between slices
   a_no_lat_idle: assert property (@(posedge clk) disable iff (!nrst)
      state == WAIT_FOR_NEXT_SLICE |-> !ctrl.lat_req);

endmodule

`default_nettype wire

// ==== design/sin_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module sin_mapper import pov_driver_pkg::*; (
   input seq_ctrl_t ctrl,
   input logic conf_bit,
   input pixel_col_t data_in,
   output logic [N_DRIVERS-1:0] drivers_sin
);

   // LED position routed to this shift slot for a given driver
   function automatic logic [3:0] slot_pos(input int drv, input logic [3:0] led,
         input logic [1:0] rgb);
      logic [3:0] pos;
      if (drv < N_DRIVERS / 3) begin
         // UB*D1 wiring
         pos = (rgb == 2'd0) ? LUT1_B[led] : LUT1_RG[led];
      end else if (drv < 2 * N_DRIVERS / 3) begin
         // Same board part mounted mirrored, slot order reversed
         pos = (rgb == 2'd0) ? LUT1_RG[4'd15 - led] : LUT1_B[4'd15 - led];
      end else begin
         // UB*D0 and UB*D2 wiring
         pos = (rgb == 2'd0) ? LUT0_RG[led] : LUT0_B[led];
      end
      return pos;
   endfunction

   always_comb begin
      logic [5:0] bit_idx;
      for (int d = 0; d < N_DRIVERS; d++) begin
         bit_idx = 6'(3 * slot_pos(d, ctrl.led_idx, ctrl.rgb_idx) + ctrl.rgb_idx);
         case (ctrl.sin_sel)
            // Same configuration broadcast to every chip
            SIN_CONF: drivers_sin[d] = conf_bit;
            SIN_PIXEL: drivers_sin[d] = data_in[d][bit_idx];
            default: drivers_sin[d] = 1'b0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/driver_pins.sv ====
`timescale 1ns/1ps
`default_nettype none

module driver_pins import pov_driver_pkg::*; (
   input logic clk,
   input logic nrst,
   input logic clk_enable,
   input seq_ctrl_t ctrl,
   output logic driver_sclk,
   output logic driver_gclk,
   output logic driver_lat
);

   // Driver clocks are the enable strobe itself, gated per state
   assign driver_sclk = ctrl.sclk_en & clk_enable;
   assign driver_gclk = ctrl.gclk_en & clk_enable;

   // LAT moves half a cycle late
   // keeps hold time after the SCLK falling edge
   always_ff @(negedge clk or negedge nrst) begin
      if (!nrst) begin
         driver_lat <= 1'b0;
      end else begin
         driver_lat <= ctrl.lat_req;
      end
   end

   a_clk_gated: assert property (@(posedge clk) disable iff (!nrst)
      !clk_enable |-> !driver_sclk && !driver_gclk);

endmodule

`default_nettype wire

// ==== design/pov_driver_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pov_driver_top import pov_driver_pkg::*; (
   input logic clk,
   input logic nrst,
   input logic clk_enable,
   input drv_word_t serialized_conf,
   input logic new_configuration_ready,
   input logic position_sync,
   input pixel_col_t data_in,
   output logic driver_sclk,
   output logic driver_gclk,
   output logic driver_lat,
   output logic [N_DRIVERS-1:0] drivers_sin,
   output logic column_ready,
   output logic driver_ready
);

   seq_ctrl_t ctrl;
   logic conf_pending;
   logic conf_load;
   logic conf_shift;
   logic conf_bit;

   // Configuration word store and serializer
   conf_serializer conf_serializer_inst (
      .clk(clk),
      .nrst(nrst),
      .clk_enable(clk_enable),
      .serialized_conf(serialized_conf),
      .new_configuration_ready(new_configuration_ready),
      .conf_load(conf_load),
      .conf_shift(conf_shift),
      .conf_pending(conf_pending),
      .conf_bit(conf_bit)
   );

   // Boot, stream and idle FSM
   driver_sequencer driver_sequencer_inst (
      .clk(clk),
      .nrst(nrst),
      .clk_enable(clk_enable),
      .position_sync(position_sync),
      .conf_pending(conf_pending),
      .ctrl(ctrl),
      .conf_load(conf_load),
      .conf_shift(conf_shift),
      .column_ready(column_ready),
      .driver_ready(driver_ready)
   );

   sin_mapper sin_mapper_inst (
      .ctrl(ctrl),
      .conf_bit(conf_bit),
      .data_in(data_in),
      .drivers_sin(drivers_sin)
   );

   driver_pins driver_pins_inst (
      .clk(clk),
      .nrst(nrst),
      .clk_enable(clk_enable),
      .ctrl(ctrl),
      .driver_sclk(driver_sclk),
      .driver_gclk(driver_gclk),
      .driver_lat(driver_lat)
   );

endmodule

`default_nettype wire

// ==== tb/pov_driver_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pov_driver_tb import pov_driver_pkg::*; ();

   logic clk = 1'b0;
   logic nrst;
   logic clk_enable;
   drv_word_t serialized_conf;
   logic new_configuration_ready;
   logic position_sync;
   pixel_col_t data_in;
   logic driver_sclk;
   logic driver_gclk;
   logic driver_lat;
   logic [N_DRIVERS-1:0] drivers_sin;
   logic column_ready;
   logic driver_ready;

   // Reference model of the driver sequence
   drv_state_e ph;
   int cnt;
   int grp;
   int row;
   logic pending;
   drv_word_t stored;
   drv_word_t wire_word;

   // Expected outputs
   // chk_* off where the sequence leaves a clock open
   logic chk_sclk;
   logic chk_gclk;
   logic exp_sclk;
   logic exp_gclk;
   logic exp_lat;
   logic [N_DRIVERS-1:0] exp_sin;
   logic exp_column_ready;
   logic exp_driver_ready;

   pov_driver_top pov_driver_top_inst (
      .clk(clk),
      .nrst(nrst),
      .clk_enable(clk_enable),
      .serialized_conf(serialized_conf),
      .new_configuration_ready(new_configuration_ready),
      .position_sync(position_sync),
      .data_in(data_in),
      .driver_sclk(driver_sclk),
      .driver_gclk(driver_gclk),
      .driver_lat(driver_lat),
      .drivers_sin(drivers_sin),
      .column_ready(column_ready),
      .driver_ready(driver_ready)
   );

   // 20 ns period
   always #10 clk = ~clk;

   task automatic stop_run();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic report_error(input string what);
      $display("%s", what);
      stop_run();
   endtask

   task automatic report_mismatch(input string sig, input logic [63:0] got,
         input logic [63:0] exp);
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, sig, got, exp);
      stop_run();
   endtask

   // LED position the board wires to shift slot led of driver d
   function automatic int wired_pos(input int d, input int led, input int rgb);
      int pos;
      if (d < 10) begin
         pos = (rgb == 0) ? LUT1_B[led] : LUT1_RG[led];
      end else if (d < 20) begin
         // Mirrored boards reverse the slot order
         pos = (rgb == 0) ? LUT1_RG[15 - led] : LUT1_B[15 - led];
      end else begin
         pos = (rgb == 0) ? LUT0_RG[led] : LUT0_B[led];
      end
      return pos;
   endfunction

   function automatic drv_word_t random_word();
      logic [63:0] r;
      r = {$urandom, $urandom};
      return r[CONF_BITS-1:0];
   endfunction

   task automatic enter_phase(input drv_state_e p);
      ph <= p;
      cnt <= 0;
   endtask

   // Phase tracking steps once per enabled cycle
   always @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         ph <= STALL;
         cnt <= 0;
         grp <= 0;
         row <= 0;
         pending <= 1'b1;
         stored <= CONF_DEFAULT;
         wire_word <= CONF_DEFAULT;
      end else begin
         if (new_configuration_ready) begin
            stored <= serialized_conf;
            pending <= 1'b1;
         end else if (clk_enable && ph == PREPARE_CONFIG && cnt == LAT_FCWRTEN - 1) begin
            pending <= 1'b0;
         end
         if (clk_enable) begin
            cnt <= cnt + 1;
            case (ph)
               STALL: enter_phase(PREPARE_CONFIG);
               PREPARE_CONFIG: if (cnt == LAT_FCWRTEN - 1) begin
                  enter_phase(CONFIG);
                  wire_word <= stored;
               end
               CONFIG: if (cnt == CONF_BITS) enter_phase(WRTFC_TIMING);
               WRTFC_TIMING: if (cnt == WRTFC_WAIT - 1) enter_phase(PREPARE_DUMP_CONFIG);
               PREPARE_DUMP_CONFIG: if (cnt == LAT_READFC - 1) enter_phase(DUMP_CONFIG);
               DUMP_CONFIG: if (cnt == CONF_BITS + DUMP_PAUSE - 1) begin
                  enter_phase(WAIT_FOR_NEXT_SLICE);
               end
               WAIT_FOR_NEXT_SLICE: begin
                  if (position_sync) begin
                     enter_phase(BLANKING);
                  end else if (cnt > GCLK_IDLE_CYCLES) begin
                     cnt <= cnt;
                  end
               end
               BLANKING: if (cnt == BLANKING_TIME - 1) enter_phase(PAUSE_SCLK);
               PAUSE_SCLK: enter_phase(SHIFT_REGISTER);
               SHIFT_REGISTER: if (cnt == CONF_BITS - 1) begin
                  enter_phase(PAUSE_SCLK);
                  grp <= grp + 1;
                  if (grp == WRTGS_PER_ROW - 1) begin
                     grp <= 0;
                     row <= row + 1;
                     enter_phase(BLANKING);
                     if (row == MUX_ROWS - 1) begin
                        row <= 0;
                        enter_phase(WAIT_FOR_NEXT_SLICE);
                     end
                  end
               end
               default: begin
               end
            endcase
            // Pending word restarts at the FCWRTEN prelude
            if (pending && ph inside {BLANKING, WAIT_FOR_NEXT_SLICE, PAUSE_SCLK,
                  SHIFT_REGISTER}) begin
               enter_phase(PREPARE_CONFIG);
               grp <= 0;
               row <= 0;
            end
         end
      end
   end

   always_comb begin : expected_outputs
      int led;
      int rgb;
      led = cnt / 3;
      rgb = cnt % 3;
      chk_sclk = 1'b1;
      chk_gclk = 1'b1;
      exp_sclk = 1'b0;
      exp_gclk = 1'b0;
      exp_lat = 1'b0;
      exp_sin = '0;
      case (ph)
         PREPARE_CONFIG, PREPARE_DUMP_CONFIG: begin
            chk_sclk = 1'b0;
            exp_lat = 1'b1;
         end
         // First cycle paused, then the word MSB first
         CONFIG: if (cnt != 0) begin
            exp_sclk = clk_enable;
            exp_lat = cnt >= CONF_BITS + 1 - LAT_WRTFC;
            exp_sin = {N_DRIVERS{wire_word[CONF_BITS - cnt]}};
         end
         DUMP_CONFIG: exp_sclk = clk_enable && cnt >= DUMP_PAUSE;
         WAIT_FOR_NEXT_SLICE: exp_gclk = clk_enable && cnt < GCLK_IDLE_CYCLES;
         BLANKING: exp_gclk = clk_enable && cnt != 0;
         PAUSE_SCLK: chk_gclk = 1'b0;
         SHIFT_REGISTER: begin
            exp_sclk = clk_enable;
            exp_gclk = clk_enable;
            // WRTGS on bit 47, LATGS on bits 45 to 47 of the tenth group
            exp_lat = cnt == CONF_BITS - 1
               || (grp == WRTGS_PER_ROW - 1 && cnt >= CONF_BITS - LAT_LATGS);
            for (int d = 0; d < N_DRIVERS; d++) begin
               exp_sin[d] = data_in[d][3 * wired_pos(d, led, rgb) + rgb];
            end
         end
         default: begin
         end
      endcase
   end

   assign exp_column_ready = (ph == WAIT_FOR_NEXT_SLICE && cnt == GCLK_IDLE_CYCLES)
      || (ph == SHIFT_REGISTER && cnt == CONF_BITS - 1 && grp == WRTGS_PER_ROW - 1
      && row == MUX_ROWS - 1);
   assign exp_driver_ready = ph == SHIFT_REGISTER && clk_enable;

   // Every register has taken reset after the first clock edges in reset
   a_reset_quiet: assert property (@(posedge clk) !nrst && $past(!nrst) |-> !driver_lat
      && !column_ready && !driver_ready && drivers_sin == '0 && !driver_sclk && !driver_gclk)
      else report_error("Outputs are not all low during reset");
   a_gated: assert property (@(posedge clk) disable iff (!nrst)
      !clk_enable |-> !driver_sclk && !driver_gclk)
      else report_error("A driver clock is high while clk_enable is low");
   a_sclk: assert property (@(posedge clk) disable iff (!nrst)
      chk_sclk |-> driver_sclk == exp_sclk)
      else report_mismatch("driver_sclk", $sampled(driver_sclk), $sampled(exp_sclk));
   a_gclk: assert property (@(posedge clk) disable iff (!nrst)
      chk_gclk |-> driver_gclk == exp_gclk)
      else report_mismatch("driver_gclk", $sampled(driver_gclk), $sampled(exp_gclk));
   // LAT already retimed by the falling edge before this sample
   a_lat: assert property (@(posedge clk) disable iff (!nrst) driver_lat == exp_lat)
      else report_mismatch("driver_lat", $sampled(driver_lat), $sampled(exp_lat));
   a_sin: assert property (@(posedge clk) disable iff (!nrst) drivers_sin == exp_sin)
      else report_mismatch("drivers_sin", $sampled(drivers_sin), $sampled(exp_sin));
   a_column_ready: assert property (@(posedge clk) disable iff (!nrst)
      column_ready == exp_column_ready)
      else report_mismatch("column_ready", $sampled(column_ready),
         $sampled(exp_column_ready));
   a_driver_ready: assert property (@(posedge clk) disable iff (!nrst)
      driver_ready == exp_driver_ready)
      else report_mismatch("driver_ready", $sampled(driver_ready),
         $sampled(exp_driver_ready));

   // New random enable strobe on each falling edge
   task automatic next_cycle();
      @(negedge clk);
      clk_enable = ($urandom % 4) != 0;
   endtask

   task automatic wait_for_phase(input drv_state_e p, input int limit);
      int n;
      n = 0;
      while (ph != p) begin
         if (n == limit) begin
            report_error($sformatf("Timeout waiting for phase %s", p.name()));
         end else begin
            next_cycle();
            n++;
         end
      end
   endtask

   task automatic wait_for_column_ready(input int limit);
      int n;
      n = 0;
      while (!column_ready) begin
         if (n == limit) begin
            report_error("Timeout waiting for column_ready");
         end else begin
            next_cycle();
            n++;
         end
      end
   endtask

   // Hold the rotor strobe until the sequencer takes it
   task automatic sync_position();
      position_sync = 1'b1;
      wait_for_phase(BLANKING, 100);
      position_sync = 1'b0;
   endtask

   task automatic randomize_pixels();
      for (int d = 0; d < N_DRIVERS; d++) begin
         data_in[d] = random_word();
      end
   endtask

   initial begin
      void'($urandom(32'ha494e805));
      nrst = 1'b0;
      clk_enable = 1'b0;
      serialized_conf = '0;
      new_configuration_ready = 1'b0;
      position_sync = 1'b0;
      data_in = '0;
      repeat (16) next_cycle();
      nrst = 1'b1;
      // Boot, then idle GCLK run
      wait_for_phase(WAIT_FOR_NEXT_SLICE, 1000);
      wait_for_column_ready(2000);
      // One full slice of eight rows
      randomize_pixels();
      sync_position();
      wait_for_phase(WAIT_FOR_NEXT_SLICE, 10000);
      wait_for_column_ready(2000);
      // Second slice with a new configuration mid-stream
      randomize_pixels();
      sync_position();
      wait_for_phase(SHIFT_REGISTER, 500);
      repeat (700) next_cycle();
      serialized_conf = random_word();
      new_configuration_ready = 1'b1;
      next_cycle();
      new_configuration_ready = 1'b0;
      wait_for_phase(PREPARE_CONFIG, 100);
      wait_for_phase(WAIT_FOR_NEXT_SLICE, 1000);
      wait_for_column_ready(2000);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// ==== pov_driver.f ====
design/pov_driver_pkg.sv
design/conf_serializer.sv
design/driver_sequencer.sv
design/sin_mapper.sv
design/driver_pins.sv
design/pov_driver_top.sv
tb/pov_driver_tb.sv

// ==== Bender.yml ====
package:
  name: pov_driver

sources:
  - design/pov_driver_pkg.sv
  - design/conf_serializer.sv
  - design/driver_sequencer.sv
  - design/sin_mapper.sv
  - design/driver_pins.sv
  - design/pov_driver_top.sv
  - target: test
    files:
      - tb/pov_driver_tb.sv
